// File: build.f
+incdir+hw
+incdir+test
hw/rob_pkg.sv
hw/rob_buffer.sv
hw/dispatch_ctrl.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/rob_core.sv
test/tb_rob_core.sv

// File: Makefile
VERILATOR  = verilator
FILELIST   = build.f
TB_TOP     = tb_rob_core
RTL_TOP    = rob_core
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully
FAIL_MSG   = Test failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/rob_ref_model.svh
`ifndef ROB_REF_MODEL_SVH
`define ROB_REF_MODEL_SVH

// Fields one retiring instruction is expected to show
typedef struct packed {
    logic [31:0] value;
    logic [4:0]  dest;
    logic [6:0]  phys;
    logic        reg_write;
    logic [31:0] pc;
} commit_rec_t;

commit_rec_t expect_q[$];    // Program order, oldest at the front

// Architectural result of one operation
function automatic logic [31:0] model_result(input op_t op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        OP_MUL:  return prod[31:0];                        // Low word only
        OP_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
        OP_REMU: return (b == 32'd0) ? a : a % b;          // Zero divisor keeps dividend
        default: return 32'd0;
    endcase
endfunction

// Record an accepted instruction
function automatic void push_expected(input op_t op, input logic [31:0] a,
                                      input logic [31:0] b, input logic [31:0] instr,
                                      input logic [6:0] phys, input logic [31:0] pc,
                                      input logic reg_write);
    commit_rec_t rec;
    rec.value     = model_result(op, a, b);
    rec.dest      = instr[11:7];    // rd field
    rec.phys      = phys;
    rec.reg_write = reg_write;
    rec.pc        = pc;
    expect_q.push_back(rec);
endfunction

`endif

// File: test/tb_rob_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module tb_rob_core
    import rob_pkg::*;
();

    localparam int N_ALU    = 200;
    localparam int N_MIX    = 300;
    localparam int N_CORNER = 14;
    localparam int N_FILL   = 6 * 19;    // Six rounds, one divide plus 18 others
    localparam int N_TOTAL  = N_ALU + N_MIX + N_CORNER + N_FILL;

    logic        clk, rst;
    logic        in_valid, in_reg_write, in_ready;
    op_t         in_op;
    logic [31:0] in_a, in_b, in_instr, in_pc;
    logic [6:0]  in_phys_addr;
    logic        commit_valid, commit_reg_write;
    logic [31:0] commit_value, commit_pc;
    logic [4:0]  commit_dest;
    logic [6:0]  commit_phys_addr;
    int          accepted, committed, errors, checks_ok;
    logic        saw_full;
    logic [31:0] next_pc;

    `include "rob_ref_model.svh"

    rob_core u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
        .in_instr(in_instr), .in_phys_addr(in_phys_addr), .in_pc(in_pc),
        .in_reg_write(in_reg_write), .in_ready(in_ready), .commit_valid(commit_valid),
        .commit_value(commit_value), .commit_dest(commit_dest),
        .commit_phys_addr(commit_phys_addr), .commit_reg_write(commit_reg_write),
        .commit_pc(commit_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    // Watchdog, 40 cycles per instruction plus margin
    initial begin
        repeat (N_TOTAL * 40 + 500) @(posedge clk);
        $display("Watchdog timeout after %0d cycles, run stopped", N_TOTAL * 40 + 500);
        $display("Test failed");
        $finish;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: commit %s got %h expected %h", $time, name, got, exp);
            errors++;
        end else begin
            checks_ok++;
        end
    endtask

    // Pop the oldest expected entry on every retire pulse
    task automatic check_commit();
        commit_rec_t exp;
        if (commit_valid) begin
            committed++;
            if (expect_q.size() == 0) begin
                $display("Retire pulse at %0t ns with nothing outstanding", $time);
                errors++;
            end else begin
                exp = expect_q.pop_front();
                compare_field("value", commit_value, exp.value);
                compare_field("dest", 32'(commit_dest), 32'(exp.dest));
                compare_field("phys", 32'(commit_phys_addr), 32'(exp.phys));
                compare_field("reg_write", 32'(commit_reg_write), 32'(exp.reg_write));
                compare_field("pc", commit_pc, exp.pc);
            end
        end
    endtask

    // One clock from falling edge to falling edge
    task automatic tick(output logic acc);
        int outstanding;
        #1;    // Inputs settled, in_ready now stable until the edge
        outstanding = accepted - committed;
        acc = in_valid && in_ready;
        if (outstanding == `ROB_DEPTH) begin
            saw_full = 1'b1;
            if (in_ready) begin
                $display("Fail at %0t ns: in_ready high with the ROB full", $time);
                errors++;
            end
        end
        @(negedge clk);
        if (acc) begin
            push_expected(in_op, in_a, in_b, in_instr, in_phys_addr, in_pc, in_reg_write);
            accepted++;
        end
        check_commit();
        if (accepted - committed > `ROB_DEPTH) begin
            $display("More than %0d instructions outstanding at %0t ns", `ROB_DEPTH, $time);
            errors++;
        end
    endtask

    // Hold the instruction until the DUT takes it
    task automatic send(input op_t op, input logic [31:0] a, input logic [31:0] b);
        logic acc;
        in_valid     = 1'b1;
        in_op        = op;
        in_a         = a;
        in_b         = b;
        in_instr     = $urandom;
        in_phys_addr = 7'($urandom);
        in_pc        = next_pc;
        in_reg_write = 1'($urandom);
        acc = 1'b0;
        while (!acc) tick(acc);
        next_pc  = next_pc + 32'd4;
        in_valid = 1'b0;
    endtask

    task automatic idle_gap();
        logic acc;
        repeat ($urandom_range(2)) tick(acc);    // Sometimes back to back
    endtask

    // Wait until every accepted instruction has retired
    task automatic drain();
        logic acc;
        int   n;
        n = 0;
        in_valid = 1'b0;
        while (expect_q.size() != 0 && n < `ROB_DEPTH * 40) begin
            tick(acc);
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("Drain stalled, %0d instructions never retired", expect_q.size());
            errors++;
        end
    endtask

    // Small values, all ones and zero show up often
    function automatic logic [31:0] rand_operand();
        case ($urandom_range(3))
            0:       return 32'($urandom_range(15));
            1:       return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    task automatic report_test(input string name, input int err_before);
        $display("test %s finished, %0d errors", name, errors - err_before);
    endtask

    initial begin
        logic        acc;
        int          err0;
        logic [31:0] ca [7];
        logic [31:0] cb [7];
        void'($urandom(32'h9d57_abc6));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_a         = '0;
        in_b         = '0;
        in_instr     = '0;
        in_phys_addr = '0;
        in_pc        = '0;
        in_reg_write = 1'b0;
        accepted     = 0;
        committed    = 0;
        errors       = 0;
        checks_ok    = 0;
        saw_full     = 1'b0;
        next_pc      = 32'h0000_1000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        repeat (8) begin
            if (commit_valid || !in_ready) begin
                $display("Fail at %0t ns: idle ROB shows commit %b ready %b", $time,
                         commit_valid, in_ready);
                errors++;
            end else begin
                checks_ok++;
            end
            tick(acc);
        end
        report_test("reset_idle", err0);

        err0 = errors;
        repeat (N_ALU) begin
            send(op_t'(4'($urandom_range(5))), rand_operand(), rand_operand());
            idle_gap();
        end
        drain();
        report_test("alu_stream", err0);

        err0 = errors;
        repeat (N_MIX) begin
            send(op_t'(4'($urandom_range(8))), rand_operand(), rand_operand());
            idle_gap();
        end
        drain();
        report_test("mixed_stream", err0);

        // Zero divisors, divisor above dividend, all ones
        err0 = errors;
        ca = '{32'd1234, 32'hffff_ffff, 32'd0, 32'd5, 32'hffff_ffff, 32'hffff_ffff,
               32'h8000_0000};
        cb = '{32'd0, 32'd0, 32'd0, 32'd7, 32'hffff_ffff, 32'd1, 32'd3};
        for (int i = 0; i < 7; i++) begin
            send(OP_DIVU, ca[i], cb[i]);
            send(OP_REMU, ca[i], cb[i]);
        end
        drain();
        report_test("div_corners", err0);

        // A slow divide at the head lets younger work fill the ROB
        err0 = errors;
        saw_full = 1'b0;
        repeat (6) begin
            send($urandom_range(1) ? OP_DIVU : OP_REMU, $urandom, rand_operand());
            repeat (18) send(op_t'(4'($urandom_range(6))), rand_operand(), rand_operand());
        end
        drain();
        if (!saw_full) begin
            $display("ROB never reached %0d entries during the fill test", `ROB_DEPTH);
            errors++;
        end
        report_test("rob_fill", err0);

        err0 = errors;
        if (expect_q.size() != 0 || accepted != committed || !in_ready) begin
            $display("Fail at %0t ns: after drain %0d accepted, %0d retired, ready %b",
                     $time, accepted, committed, in_ready);
            errors++;
        end else begin
            checks_ok++;
        end
        report_test("final_drain", err0);

        $display("checks passed %0d, checks failed %0d", checks_ok, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/rob_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_core
    import rob_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  op_t         in_op,
    input  logic [31:0] in_a,
    input  logic [31:0] in_b,
    input  logic [31:0] in_instr,
    input  logic [6:0]  in_phys_addr,
    input  logic [31:0] in_pc,
    input  logic        in_reg_write,
    output logic        in_ready,
    output logic        commit_valid,
    output logic [31:0] commit_value,
    output logic [4:0]  commit_dest,
    output logic [6:0]  commit_phys_addr,
    output logic        commit_reg_write,
    output logic [31:0] commit_pc
);

    logic                  alloc, full, div_busy;
    logic [`ROB_IDX_W-1:0] alloc_idx, unit_idx;
    logic                  alu_start, mul_start, div_start;
    op_t                   unit_op;
    logic [31:0]           unit_a, unit_b;
    logic                  alu_done, mul_done, div_done;
    logic [31:0]           alu_value, mul_value, div_value;
    logic [`ROB_IDX_W-1:0] alu_idx, mul_idx, div_idx;

    dispatch_ctrl u_dispatch (
        .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
        .full(full), .div_busy(div_busy), .alloc_idx(alloc_idx),
        .in_ready(in_ready), .alloc(alloc),
        .alu_start(alu_start), .mul_start(mul_start), .div_start(div_start),
        .unit_op(unit_op), .unit_a(unit_a), .unit_b(unit_b), .unit_idx(unit_idx)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst), .start(alu_start), .op(unit_op), .a(unit_a), .b(unit_b),
        .idx(unit_idx), .done(alu_done), .value(alu_value), .done_idx(alu_idx)
    );

    mul_unit u_mul (
        .clk(clk), .rst(rst), .start(mul_start), .a(unit_a), .b(unit_b),
        .idx(unit_idx), .done(mul_done), .value(mul_value), .done_idx(mul_idx)
    );

    div_unit u_div (
        .clk(clk), .rst(rst), .start(div_start), .op(unit_op), .a(unit_a), .b(unit_b),
        .idx(unit_idx), .done(div_done), .value(div_value), .done_idx(div_idx),
        .busy(div_busy)
    );

    // Instruction fields go straight from the dispatch port into the ROB
    rob_buffer u_rob (
        .clk(clk), .rst(rst), .alloc(alloc),
        .alloc_instr(in_instr), .alloc_pc(in_pc),
        .alloc_phys_addr(in_phys_addr), .alloc_reg_write(in_reg_write),
        .alloc_idx(alloc_idx), .full(full),
        .alu_done(alu_done), .alu_value(alu_value), .alu_idx(alu_idx),
        .mul_done(mul_done), .mul_value(mul_value), .mul_idx(mul_idx),
        .div_done(div_done), .div_value(div_value), .div_idx(div_idx),
        .commit_valid(commit_valid), .commit_value(commit_value),
        .commit_dest(commit_dest), .commit_phys_addr(commit_phys_addr),
        .commit_reg_write(commit_reg_write), .commit_pc(commit_pc)
    );

endmodule

`default_nettype wire

// File: hw/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module div_unit
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  op_t                   op,
    input  logic [31:0]           a,           // Dividend
    input  logic [31:0]           b,           // Divisor
    input  logic [`ROB_IDX_W-1:0] idx,
    output logic                  done,
    output logic [31:0]           value,
    output logic [`ROB_IDX_W-1:0] done_idx,
    output logic                  busy
);

    localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

    logic [CNT_W-1:0]      cnt;                // Iterations left
    logic [31:0]           dvsr;
    logic [31:0]           rem;                // Partial remainder
    logic [31:0]           quo;                // Dividend shifts out, quotient in
    logic                  is_rem;             // Return remainder, not quotient
    logic [`ROB_IDX_W-1:0] tag;
    logic [32:0]           trial;
    logic [33:0]           diff;
    logic [31:0]           rem_nxt, quo_nxt;

    // One restoring step; a zero divisor always subtracts, giving all ones
    always_comb begin
        trial = {rem, quo[31]};                       // Bring down next dividend bit
        diff  = {1'b0, trial} - {2'b00, dvsr};
        if (!diff[33]) begin
            rem_nxt = diff[31:0];                     // Fits, keep difference
            quo_nxt = {quo[30:0], 1'b1};
        end else begin
            rem_nxt = trial[31:0];                    // Restore
            quo_nxt = {quo[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`DIV_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    busy <= 1'b0;                     // Last step also writes result
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem    <= '0;
            quo    <= a;
            dvsr   <= b;
            is_rem <= (op == OP_REMU);
            tag    <= idx;
        end else if (busy) begin
            rem <= rem_nxt;
            quo <= quo_nxt;
            if (cnt == CNT_W'(1)) begin
                value    <= is_rem ? rem_nxt : quo_nxt;
                done_idx <= tag;
            end
        end
    end

    // Dispatch holds divides back while the unit is occupied
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("Divider started while busy");

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [`ROB_IDX_W-1:0] idx,
    output logic                  done,
    output logic [31:0]           value,
    output logic [`ROB_IDX_W-1:0] done_idx
);

    logic [31:0]            a_q, b_q;                  // Stage 1, operands
    logic [31:0]            prod_q;                    // Stage 2, low product word
    logic [`MUL_STAGES-1:0] vld_pipe;                  // Valid per stage
    logic [`ROB_IDX_W-1:0]  idx_pipe [`MUL_STAGES];    // Tag per stage

    // Datapath below is written out for three stages
    if (`MUL_STAGES != 3) begin : g_stage_check
        $error("mul_unit datapath has exactly three stages");
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) vld_pipe <= '0;
        else     vld_pipe <= {vld_pipe[`MUL_STAGES-2:0], start};    // No stalls
    end

    always_ff @(posedge clk) begin
        a_q    <= a;
        b_q    <= b;
        prod_q <= a_q * b_q;    // Truncated to 32 bits
        value  <= prod_q;       // Stage 3, output register
        idx_pipe[0] <= idx;
        for (int i = 1; i < `MUL_STAGES; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
        end
    end

    assign done     = vld_pipe[`MUL_STAGES-1];
    assign done_idx = idx_pipe[`MUL_STAGES-1];

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module alu_unit
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  op_t                   op,
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [`ROB_IDX_W-1:0] idx,
    output logic                  done,
    output logic [31:0]           value,
    output logic [`ROB_IDX_W-1:0] done_idx
);

    logic [31:0] result;

    always_comb begin
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLTU: result = {31'd0, a < b};    // Unsigned compare
            default: result = '0;                // Non-ALU ops never start here
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) done <= 1'b0;
        else     done <= start;    // Pulse in the cycle after start
    end

    always_ff @(posedge clk) begin
        if (start) begin
            value    <= result;
            done_idx <= idx;
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module dispatch_ctrl
    import rob_pkg::*;
(
    input  logic                  in_valid,
    input  op_t                   in_op,
    input  logic [31:0]           in_a,
    input  logic [31:0]           in_b,
    input  logic                  full,         // From ROB
    input  logic                  div_busy,     // Divider holds an operation
    input  logic [`ROB_IDX_W-1:0] alloc_idx,    // Current ROB tail
    output logic                  in_ready,
    output logic                  alloc,
    output logic                  alu_start,
    output logic                  mul_start,
    output logic                  div_start,
    output op_t                   unit_op,
    output logic [31:0]           unit_a,
    output logic [31:0]           unit_b,
    output logic [`ROB_IDX_W-1:0] unit_idx
);

    unit_t sel_unit;
    logic  accept;

    assign sel_unit = unit_of(in_op);

    // Stall on a full ROB, or a divide when the divider is taken
    assign in_ready = !full && !(sel_unit == UNIT_DIV && div_busy);
    assign accept   = in_valid && in_ready;

    assign alloc     = accept;                              // One slot per accepted op
    assign alu_start = accept && (sel_unit == UNIT_ALU);    // Exactly one start fires
    assign mul_start = accept && (sel_unit == UNIT_MUL);
    assign div_start = accept && (sel_unit == UNIT_DIV);

    // Shared operand bus, only the started unit samples it
    assign unit_op  = in_op;
    assign unit_a   = in_a;
    assign unit_b   = in_b;
    assign unit_idx = alloc_idx;    // Tag is the slot being allocated

endmodule

`default_nettype wire

// File: hw/rob_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc,            // New entry at tail
    input  logic [31:0]           alloc_instr,
    input  logic [31:0]           alloc_pc,
    input  logic [6:0]            alloc_phys_addr,
    input  logic                  alloc_reg_write,
    output logic [`ROB_IDX_W-1:0] alloc_idx,        // Tail, used as unit tag
    output logic                  full,
    input  logic                  alu_done,
    input  logic [31:0]           alu_value,
    input  logic [`ROB_IDX_W-1:0] alu_idx,
    input  logic                  mul_done,
    input  logic [31:0]           mul_value,
    input  logic [`ROB_IDX_W-1:0] mul_idx,
    input  logic                  div_done,
    input  logic [31:0]           div_value,
    input  logic [`ROB_IDX_W-1:0] div_idx,
    output logic                  commit_valid,     // One-cycle retire pulse
    output logic [31:0]           commit_value,
    output logic [4:0]            commit_dest,
    output logic [6:0]            commit_phys_addr,
    output logic                  commit_reg_write,
    output logic [31:0]           commit_pc
);

    logic [`ROB_DEPTH-1:0] slot_busy;                 // Allocated, not yet retired
    logic [`ROB_DEPTH-1:0] slot_ready;                // Result written back
    logic [31:0]           slot_value [`ROB_DEPTH];
    logic [31:0]           slot_instr [`ROB_DEPTH];
    logic [6:0]            slot_phys  [`ROB_DEPTH];
    logic [31:0]           slot_pc    [`ROB_DEPTH];
    logic                  slot_wr    [`ROB_DEPTH];

    logic [`ROB_IDX_W-1:0] head;                      // Oldest entry
    logic [`ROB_IDX_W-1:0] tail;                      // Next free slot
    logic [`ROB_IDX_W:0]   count;                     // Occupancy, one extra bit for full
    logic                  do_commit;

    assign do_commit = slot_busy[head] && slot_ready[head];    // Head finished
    assign full      = (count == (`ROB_IDX_W+1)'(`ROB_DEPTH));
    assign alloc_idx = tail;

    // Pointers, flags and the retire pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            slot_busy    <= '0;
            slot_ready   <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc) begin
                slot_busy[tail]  <= 1'b1;
                slot_ready[tail] <= 1'b0;
                tail             <= tail + 1'b1;    // Depth is a power of two, wraps
            end
            if (alu_done) slot_ready[alu_idx] <= 1'b1;    // Direct index, no search
            if (mul_done) slot_ready[mul_idx] <= 1'b1;
            if (div_done) slot_ready[div_idx] <= 1'b1;
            commit_valid <= do_commit;
            if (do_commit) begin
                slot_busy[head]  <= 1'b0;           // Slot free from next cycle
                slot_ready[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            case ({alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither, no change
            endcase
        end
    end

    // Entry payload and registered commit fields
    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_instr[tail] <= alloc_instr;
            slot_phys[tail]  <= alloc_phys_addr;
            slot_pc[tail]    <= alloc_pc;
            slot_wr[tail]    <= alloc_reg_write;
        end
        if (alu_done) slot_value[alu_idx] <= alu_value;
        if (mul_done) slot_value[mul_idx] <= mul_value;
        if (div_done) slot_value[div_idx] <= div_value;
        if (do_commit) begin
            commit_value     <= slot_value[head];
            commit_dest      <= slot_instr[head][`DEST_HI:`DEST_LO];    // rd field
            commit_phys_addr <= slot_phys[head];
            commit_reg_write <= slot_wr[head];
            commit_pc        <= slot_pc[head];
        end
    end

    // Dispatch must respect the full flag
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !full)
        else $error("ROB allocation while full");

    // Units only report slots that dispatch handed out
    a_done_busy: assert property (@(posedge clk) disable iff (rst)
        (alu_done |-> slot_busy[alu_idx]) and
        (mul_done |-> slot_busy[mul_idx]) and
        (div_done |-> slot_busy[div_idx]))
        else $error("Completion into a free ROB slot");

    // Tags are unique across units
    a_done_unique: assert property (@(posedge clk) disable iff (rst)
        !(alu_done && mul_done && alu_idx == mul_idx) &&
        !(alu_done && div_done && alu_idx == div_idx) &&
        !(mul_done && div_done && mul_idx == div_idx))
        else $error("Two completions with the same ROB index");

endmodule

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Nine operations, so the encoding needs four bits
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,       // a + b
        OP_SUB  = 4'd1,       // a - b
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLTU = 4'd5,       // Unsigned a < b, result 0 or 1
        OP_MUL  = 4'd6,       // Low word of a * b
        OP_DIVU = 4'd7,       // Unsigned quotient
        OP_REMU = 4'd8        // Unsigned remainder
    } op_t;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_t;

    // Steering table, everything not mul or div is ALU work
    function automatic unit_t unit_of(input op_t op);
        case (op)
            OP_MUL:           return UNIT_MUL;
            OP_DIVU, OP_REMU: return UNIT_DIV;
            default:          return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Reorder buffer sizing
`define ROB_DEPTH 16          // Slots in the ROB
`define ROB_IDX_W 4           // Slot index width, log2 of depth

// Execution unit latencies
`define MUL_STAGES 3          // Operand, multiply, output register
`define DIV_CYCLES 32         // One quotient bit per iteration

// Fixed datapath widths
`define DATA_W 32             // Operand and result width
`define PHYS_W 7              // Physical register address width
`define DEST_LO 7             // Low bit of rd in the instruction word
`define DEST_HI 11            // High bit of rd in the instruction word

`endif
